/* hdl/pad_mux_pkg.sv */
/*
 * Widths, select codes and pad positions shared by the pad multiplexer.
 * Select codes that no mode uses fall back to PAD_IDLE: all inputs, output high.
 */
package pad_mux_pkg;

    // Bus widths
    localparam int PAD_COUNT      = 38;  // User IO pads
    localparam int LA_WIDTH       = 16;  // LA subset routed into the mux
    localparam int SEL_WIDTH      = 4;
    localparam int SLOT_COUNT     = 3;   // Designs kept on this padframe
    localparam int TT_BYTE_WIDTH  = 8;   // TinyTapeout uo/uio byte
    localparam int RGB_WIDTH      = 6;   // 2 bits per colour
    localparam int GPOUT_WIDTH    = 3;
    localparam int HYPERRAM_WIDTH = 13;

    typedef logic [PAD_COUNT-1:0]      pad_vec_t;
    typedef logic [LA_WIDTH-1:0]       la_vec_t;
    typedef logic [SEL_WIDTH-1:0]      mux_sel_t;
    typedef logic [SLOT_COUNT-1:0]     slot_vec_t;
    typedef logic [TT_BYTE_WIDTH-1:0]  tt_byte_t;
    typedef logic [RGB_WIDTH-1:0]      rgb_t;
    typedef logic [GPOUT_WIDTH-1:0]    gpout_t;
    typedef logic [HYPERRAM_WIDTH-1:0] hyperram_vec_t;

    // Select codes, as driven from the LA
    localparam mux_sel_t SEL_RAYBOX      = 4'd0;
    localparam mux_sel_t SEL_HYPERRAM    = 4'd2;
    localparam mux_sel_t SEL_VGA_SPI_ROM = 4'd6;
    localparam mux_sel_t SEL_LOOPBACK    = 4'd11;
    localparam mux_sel_t SEL_PATTERN     = 4'd13;
    localparam mux_sel_t SEL_PATTERN_INV = 4'd14;
    localparam mux_sel_t SEL_IDLE        = 4'd15;  // Loaded at reset, unmapped

    // Bit positions in slot_vec_t
    localparam int SLOT_RAYBOX      = 0;
    localparam int SLOT_HYPERRAM    = 1;
    localparam int SLOT_VGA_SPI_ROM = 2;

    // Select code that activates each slot
    localparam mux_sel_t SLOT_SEL_CODES [SLOT_COUNT] = '{
        SLOT_RAYBOX:      SEL_RAYBOX,
        SLOT_HYPERRAM:    SEL_HYPERRAM,
        SLOT_VGA_SPI_ROM: SEL_VGA_SPI_ROM
    };

    // Pad input that may reset all designs
    localparam int IO5_RESET_PAD = 5;

    // Raybox pad groups
    localparam int RAYBOX_GPOUT_LSB = 35;  // gpout on 37:35
    localparam int RAYBOX_RGB_LSB   = 10;  // rgb on 15:10

    // HyperRAM owns the top of the padframe
    localparam int HYPERRAM_PAD_LSB = 25;  // 37:25

    // Loopback mode
    localparam int LOOP_WIDTH   = 7;
    localparam int LOOP_SRC_LSB = 31;  // Pads 37:31 read as inputs
    localparam int LOOP_DST_LSB = 24;  // ... echoed on 30:24
    localparam int LA_PAD_LSB   = 8;   // LA echoed on 23:8

    // Pattern modes
    localparam int      PATTERN_PAD_LSB = 16;  // Pattern on 31:16
    localparam la_vec_t TEST_PATTERN    = 16'h55AA;

    // Idle pads: input direction, output level 1
    localparam pad_vec_t PAD_IDLE = '1;

endpackage

/* hdl/mux_ctrl_sync.sv */
/*
 * Select bits are synchronised one by one; hold i_mux_sel steady while it settles.
 * Controls are plain LA levels with no handshake, two edges of latency.
 */
`timescale 1ns/1ps

module mux_ctrl_sync (
    input  logic                  mux_conf_clk,
    input  logic                  i_rst_n,

    input  pad_mux_pkg::mux_sel_t i_mux_sel,
    input  logic                  i_mux_sys_reset_enb,   // Active low
    input  logic                  i_mux_io5_reset_enb,   // Active low
    input  logic                  i_mux_auto_reset_enb,  // Active low

    output pad_mux_pkg::mux_sel_t o_mux_sel,
    output logic                  o_sys_reset_ena,
    output logic                  o_io5_reset_ena,
    output logic                  o_auto_reset_ena
);
    import pad_mux_pkg::*;

    // First stage may go metastable, second is clean
    mux_sel_t   sel_meta;
    mux_sel_t   sel_sync;
    logic [2:0] enb_meta;  // {auto, io5, sys}, still active low
    logic [2:0] enb_sync;

    always_ff @(posedge mux_conf_clk) begin
        if (!i_rst_n) begin
            sel_meta <= SEL_IDLE;  // Default mode, pads idle
            sel_sync <= SEL_IDLE;
            enb_meta <= '1;        // All enables off
            enb_sync <= '1;
        end else begin
            sel_meta <= i_mux_sel;
            sel_sync <= sel_meta;
            enb_meta <= {i_mux_auto_reset_enb,
                         i_mux_io5_reset_enb,
                         i_mux_sys_reset_enb};
            enb_sync <= enb_meta;
        end
    end

    assign o_mux_sel = sel_sync;

    // enb to ena
    assign o_sys_reset_ena  = ~enb_sync[0];
    assign o_io5_reset_ena  = ~enb_sync[1];
    assign o_auto_reset_ena = ~enb_sync[2];

endmodule

/* hdl/design_reset_gen.sv */
/*
 * Purely combinational; resets are active high and may glitch on select changes.
 * Only designs listed in SLOT_SEL_CODES get a reset and an enable.
 */
`timescale 1ns/1ps

module design_reset_gen (
    input  pad_mux_pkg::mux_sel_t  i_mux_sel,         // Synchronised select

    input  logic                   i_sys_reset_ena,
    input  logic                   i_io5_reset_ena,
    input  logic                   i_auto_reset_ena,

    input  logic                   i_sys_rst,         // System reset, raw
    input  logic                   i_io5_pad,         // Pad 5 input level
    input  pad_mux_pkg::slot_vec_t i_design_reset,    // Direct per-design reset

    output pad_mux_pkg::slot_vec_t o_design_rst,
    output pad_mux_pkg::slot_vec_t o_design_ena
);
    import pad_mux_pkg::*;

    logic      sys_reset;  // System reset once gated
    logic      io5_reset;  // Pad reset once gated
    slot_vec_t slot_hit;   // One-hot, select matches slot

    assign sys_reset = i_sys_reset_ena & i_sys_rst;
    assign io5_reset = i_io5_reset_ena & i_io5_pad;

    // Compare the select against each slot's code
    always_comb begin
        for (int k = 0; k < SLOT_COUNT; k++) begin
            slot_hit[k] = (i_mux_sel == SLOT_SEL_CODES[k]);
        end
    end

    // Any source resets the design
    always_comb begin
        for (int k = 0; k < SLOT_COUNT; k++) begin
            o_design_rst[k] = i_design_reset[k]
                            | (i_auto_reset_ena & ~slot_hit[k])  // Park idle designs
                            | sys_reset
                            | io5_reset;
        end
    end

    assign o_design_ena = slot_hit;  // Only the selected design runs

endmodule

/* hdl/pad_mux_select.sv */
/*
 * Combinational pad driver; an oeb bit of 1 means the pad is an input.
 * Pads not claimed by the selected mode stay input with output high.
 */
`timescale 1ns/1ps

module pad_mux_select (
    input  pad_mux_pkg::mux_sel_t      i_mux_sel,
    input  pad_mux_pkg::pad_vec_t      i_io_in,
    input  pad_mux_pkg::la_vec_t       i_la_in,

    // Raybox renderer
    input  logic                       i_raybox_hsync,
    input  logic                       i_raybox_vsync,
    input  logic                       i_raybox_tex_csb,
    input  logic                       i_raybox_tex_sclk,
    input  logic                       i_raybox_tex_out0,
    input  logic                       i_raybox_tex_oeb0,   // Pad 18 direction
    input  pad_mux_pkg::rgb_t          i_raybox_rgb,
    input  pad_mux_pkg::gpout_t        i_raybox_gpout,

    // HyperRAM bridge, drives its own directions
    input  pad_mux_pkg::hyperram_vec_t i_hyperram_io_out,
    input  pad_mux_pkg::hyperram_vec_t i_hyperram_io_oeb,

    // VGA SPI ROM, TinyTapeout-style ports
    input  pad_mux_pkg::tt_byte_t      i_vga_uo_out,
    input  pad_mux_pkg::tt_byte_t      i_vga_uio_out,
    input  pad_mux_pkg::tt_byte_t      i_vga_uio_oe,        // 1 = output

    output pad_mux_pkg::pad_vec_t      o_io_out,
    output pad_mux_pkg::pad_vec_t      o_io_oeb
);
    import pad_mux_pkg::*;

    always_comb begin
        // Idle base, each mode overlays its own pads
        o_io_out = PAD_IDLE;
        o_io_oeb = PAD_IDLE;

        case (i_mux_sel)
            SEL_RAYBOX: begin
                o_io_out[RAYBOX_GPOUT_LSB +: GPOUT_WIDTH] = i_raybox_gpout;  // 37:35
                o_io_oeb[RAYBOX_GPOUT_LSB +: GPOUT_WIDTH] = '0;
                // 34:19 stay inputs
                o_io_out[18] = i_raybox_tex_out0;    // Texture SPI io0, bidir
                o_io_oeb[18] = i_raybox_tex_oeb0;
                o_io_out[17] = i_raybox_tex_sclk;
                o_io_out[16] = i_raybox_tex_csb;
                o_io_out[RAYBOX_RGB_LSB +: RGB_WIDTH] = i_raybox_rgb;  // 15:10
                o_io_out[9]  = i_raybox_vsync;
                o_io_out[8]  = i_raybox_hsync;
                o_io_oeb[17:8] = '0;                 // Video and SPI clock/select out
            end

            SEL_HYPERRAM: begin
                // Bridge owns 37:25 outright
                o_io_out[HYPERRAM_PAD_LSB +: HYPERRAM_WIDTH] = i_hyperram_io_out;
                o_io_oeb[HYPERRAM_PAD_LSB +: HYPERRAM_WIDTH] = i_hyperram_io_oeb;
            end

            SEL_VGA_SPI_ROM: begin
                // SPI on the same pads as the raybox texture ROM
                o_io_out[37] = i_vga_uio_out[5];     // SPI reset, bidir
                o_io_oeb[37] = ~i_vga_uio_oe[5];
                o_io_out[36] = i_vga_uio_out[4];     // Test out
                o_io_oeb[36] = 1'b0;
                // 35:19 stay inputs, incl. spi_in[3:1] and mode straps
                o_io_out[18] = i_vga_uio_out[1];     // SPI io0, bidir
                o_io_oeb[18] = ~i_vga_uio_oe[1];
                o_io_out[17] = i_vga_uio_out[3];     // sclk
                o_io_out[16] = i_vga_uio_out[0];     // csb

                // VGA bits reordered to the raybox pinout
                o_io_out[15] = i_vga_uo_out[2];      // b1
                o_io_out[14] = i_vga_uo_out[6];      // b0
                o_io_out[13] = i_vga_uo_out[1];      // g1
                o_io_out[12] = i_vga_uo_out[5];      // g0
                o_io_out[11] = i_vga_uo_out[0];      // r1
                o_io_out[10] = i_vga_uo_out[4];      // r0
                o_io_out[9]  = i_vga_uo_out[3];      // vsync
                o_io_out[8]  = i_vga_uo_out[7];      // hsync
                o_io_oeb[17:8] = '0;
            end

            SEL_LOOPBACK: begin
                // Top pads come back out a few pads lower
                o_io_out[LOOP_DST_LSB +: LOOP_WIDTH] = i_io_in[LOOP_SRC_LSB +: LOOP_WIDTH];
                o_io_oeb[LOOP_DST_LSB +: LOOP_WIDTH] = '0;
                o_io_out[LA_PAD_LSB +: LA_WIDTH] = i_la_in;  // 23:8
                o_io_oeb[LA_PAD_LSB +: LA_WIDTH] = '0;
            end

            SEL_PATTERN: begin
                o_io_out[PATTERN_PAD_LSB +: LA_WIDTH] = TEST_PATTERN;  // 31:16
                o_io_oeb[PATTERN_PAD_LSB +: LA_WIDTH] = '0;
            end

            SEL_PATTERN_INV: begin
                // Every bit flips, catches stuck pads
                o_io_out[PATTERN_PAD_LSB +: LA_WIDTH] = ~TEST_PATTERN;
                o_io_oeb[PATTERN_PAD_LSB +: LA_WIDTH] = '0;
            end

            default: ;  // Unused codes and reset value 15 keep the idle base
        endcase
    end

endmodule

/* hdl/pad_mux_top.sv */
/*
 * Designs take the system clock and raw pad inputs directly, not through this block.
 * Mux controls come in on mux_conf_clk; the rest of the path is combinational.
 */
`timescale 1ns/1ps

module pad_mux_top (
    input  logic                       mux_conf_clk,
    input  logic                       i_rst_n,

    // Mux controls, from the LA
    input  pad_mux_pkg::mux_sel_t      i_mux_sel,
    input  logic                       i_mux_sys_reset_enb,
    input  logic                       i_mux_io5_reset_enb,
    input  logic                       i_mux_auto_reset_enb,

    input  logic                       i_sys_rst,
    input  pad_mux_pkg::pad_vec_t      i_io_in,
    input  pad_mux_pkg::la_vec_t       i_la_in,
    input  pad_mux_pkg::slot_vec_t     i_design_reset,

    // Design outputs coming into the mux
    input  logic                       i_raybox_hsync,
    input  logic                       i_raybox_vsync,
    input  logic                       i_raybox_tex_csb,
    input  logic                       i_raybox_tex_sclk,
    input  logic                       i_raybox_tex_out0,
    input  logic                       i_raybox_tex_oeb0,
    input  pad_mux_pkg::rgb_t          i_raybox_rgb,
    input  pad_mux_pkg::gpout_t        i_raybox_gpout,
    input  pad_mux_pkg::hyperram_vec_t i_hyperram_io_out,
    input  pad_mux_pkg::hyperram_vec_t i_hyperram_io_oeb,
    input  pad_mux_pkg::tt_byte_t      i_vga_uo_out,
    input  pad_mux_pkg::tt_byte_t      i_vga_uio_out,
    input  pad_mux_pkg::tt_byte_t      i_vga_uio_oe,

    output pad_mux_pkg::pad_vec_t      o_io_out,
    output pad_mux_pkg::pad_vec_t      o_io_oeb,
    output pad_mux_pkg::slot_vec_t     o_design_rst,
    output pad_mux_pkg::slot_vec_t     o_design_ena
);
    import pad_mux_pkg::*;

    mux_sel_t mux_sel;         // Synchronised select
    logic     sys_reset_ena;
    logic     io5_reset_ena;
    logic     auto_reset_ena;

    mux_ctrl_sync i_mux_ctrl_sync (
        .mux_conf_clk         (mux_conf_clk),
        .i_rst_n              (i_rst_n),
        .i_mux_sel            (i_mux_sel),
        .i_mux_sys_reset_enb  (i_mux_sys_reset_enb),
        .i_mux_io5_reset_enb  (i_mux_io5_reset_enb),
        .i_mux_auto_reset_enb (i_mux_auto_reset_enb),
        .o_mux_sel            (mux_sel),
        .o_sys_reset_ena      (sys_reset_ena),
        .o_io5_reset_ena      (io5_reset_ena),
        .o_auto_reset_ena     (auto_reset_ena)
    );

    design_reset_gen i_design_reset_gen (
        .i_mux_sel        (mux_sel),
        .i_sys_reset_ena  (sys_reset_ena),
        .i_io5_reset_ena  (io5_reset_ena),
        .i_auto_reset_ena (auto_reset_ena),
        .i_sys_rst        (i_sys_rst),
        .i_io5_pad        (i_io_in[IO5_RESET_PAD]),  // Board reset button pad
        .i_design_reset   (i_design_reset),
        .o_design_rst     (o_design_rst),
        .o_design_ena     (o_design_ena)
    );

    pad_mux_select i_pad_mux_select (
        .i_mux_sel         (mux_sel),
        .i_io_in           (i_io_in),
        .i_la_in           (i_la_in),
        .i_raybox_hsync    (i_raybox_hsync),
        .i_raybox_vsync    (i_raybox_vsync),
        .i_raybox_tex_csb  (i_raybox_tex_csb),
        .i_raybox_tex_sclk (i_raybox_tex_sclk),
        .i_raybox_tex_out0 (i_raybox_tex_out0),
        .i_raybox_tex_oeb0 (i_raybox_tex_oeb0),
        .i_raybox_rgb      (i_raybox_rgb),
        .i_raybox_gpout    (i_raybox_gpout),
        .i_hyperram_io_out (i_hyperram_io_out),
        .i_hyperram_io_oeb (i_hyperram_io_oeb),
        .i_vga_uo_out      (i_vga_uo_out),
        .i_vga_uio_out     (i_vga_uio_out),
        .i_vga_uio_oe      (i_vga_uio_oe),
        .o_io_out          (o_io_out),
        .o_io_oeb          (o_io_oeb)
    );

endmodule

/* tests/tb_pad_mux_tasks.svh */
/*
 * Included inside tb_pad_mux_top; tasks drive and read its DUT signals directly.
 * Callers start each drive on a falling edge, checks land 1 ns after it.
 */

// Slot select codes, slot 0 in the low nibble
localparam logic [11:0] SLOT_CODES_REF = {4'd6, 4'd2, 4'd0};
localparam logic [11:0] IDLE_SELS      = {4'd15, 4'd7, 4'd3};  // Unmapped codes
// uo_out bit on pads 15 down to 8
localparam logic [23:0] VGA_UO_ORDER   = {3'd2, 3'd6, 3'd1, 3'd5, 3'd0, 3'd4, 3'd3, 3'd7};

task automatic check_value(input string test_name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (actual !== expected) begin
        $display("Error: %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "Stopped at the first mismatch");
    end
endtask

// ena is {auto, io5, sys}, active high
task automatic set_controls(input mux_sel_t sel, input logic [2:0] ena);
    i_mux_sel            = sel;
    i_mux_sys_reset_enb  = ~ena[0];
    i_mux_io5_reset_enb  = ~ena[1];
    i_mux_auto_reset_enb = ~ena[2];
endtask

task automatic wait_sync();
    repeat (2) @(negedge mux_conf_clk);  // Two rising edges through both flops
endtask

task automatic randomize_design_outputs();
    {i_raybox_hsync, i_raybox_vsync, i_raybox_tex_csb} = 3'($urandom);
    {i_raybox_tex_sclk, i_raybox_tex_out0, i_raybox_tex_oeb0} = 3'($urandom);
    i_raybox_rgb      = rgb_t'($urandom);
    i_raybox_gpout    = gpout_t'($urandom);
    i_hyperram_io_out = hyperram_vec_t'($urandom);
    i_hyperram_io_oeb = hyperram_vec_t'($urandom);
    i_vga_uo_out      = tt_byte_t'($urandom);
    i_vga_uio_out     = tt_byte_t'($urandom);
    i_vga_uio_oe      = tt_byte_t'($urandom);  // Both directions on pads 37 and 18
endtask

task automatic randomize_pad_inputs();
    i_io_in = pad_vec_t'({$urandom, $urandom});  // Pad 5 included
    i_la_in = la_vec_t'($urandom);
endtask

// Reference pad mapping, idle unless a mode claims the pad
task automatic model_pads(input mux_sel_t sel, output pad_vec_t exp_out,
                          output pad_vec_t exp_oeb);
    exp_out = '1;
    exp_oeb = '1;
    case (sel)
        4'd0: begin
            exp_out[37:35] = i_raybox_gpout;
            exp_out[18]    = i_raybox_tex_out0;
            exp_oeb[18]    = i_raybox_tex_oeb0;  // Renderer picks the direction
            exp_out[17]    = i_raybox_tex_sclk;
            exp_out[16]    = i_raybox_tex_csb;
            exp_out[15:10] = i_raybox_rgb;
            exp_out[9]     = i_raybox_vsync;
            exp_out[8]     = i_raybox_hsync;
            exp_oeb[37:35] = 3'b000;
            exp_oeb[17:8]  = 10'd0;
        end
        4'd2: begin
            exp_out[37:25] = i_hyperram_io_out;
            exp_oeb[37:25] = i_hyperram_io_oeb;
        end
        4'd6: begin
            exp_out[37] = i_vga_uio_out[5];
            exp_oeb[37] = !i_vga_uio_oe[5];      // oe is active high
            exp_out[36] = i_vga_uio_out[4];
            exp_oeb[36] = 1'b0;
            exp_out[18] = i_vga_uio_out[1];
            exp_oeb[18] = !i_vga_uio_oe[1];
            exp_out[17] = i_vga_uio_out[3];
            exp_out[16] = i_vga_uio_out[0];
            for (int p = 8; p < 16; p++) begin
                exp_out[p] = i_vga_uo_out[VGA_UO_ORDER[3*(p-8) +: 3]];
            end
            exp_oeb[17:8] = 10'd0;
        end
        4'd11: begin
            for (int b = 0; b < 7; b++) begin
                exp_out[24+b] = i_io_in[31+b];  // Top pads echoed
            end
            for (int b = 0; b < 16; b++) begin
                exp_out[8+b] = i_la_in[b];
            end
            exp_oeb[30:8] = 23'd0;
        end
        4'd13: begin
            exp_out[31:16] = TEST_PATTERN;
            exp_oeb[31:16] = 16'd0;
        end
        4'd14: begin
            exp_out[31:16] = ~TEST_PATTERN;
            exp_oeb[31:16] = 16'd0;
        end
        default: ;
    endcase
endtask

function automatic slot_vec_t model_ena(input mux_sel_t sel);
    slot_vec_t ena;
    for (int k = 0; k < 3; k++) begin
        ena[k] = (sel == SLOT_CODES_REF[4*k +: 4]);
    end
    return ena;
endfunction

// Four reset sources per slot
function automatic slot_vec_t model_rst(input mux_sel_t sel, input logic [2:0] ena);
    slot_vec_t rst;
    for (int k = 0; k < 3; k++) begin
        rst[k] = i_design_reset[k]
              || (ena[2] && sel != SLOT_CODES_REF[4*k +: 4])
              || (ena[0] && i_sys_rst)
              || (ena[1] && i_io_in[5]);
    end
    return rst;
endfunction

task automatic compare_pads(input string test_name, input mux_sel_t sel);
    pad_vec_t exp_out;
    pad_vec_t exp_oeb;
    #1;
    model_pads(sel, exp_out, exp_oeb);
    check_value({test_name, " io_out"}, 64'(exp_out), 64'(o_io_out));
    check_value({test_name, " io_oeb"}, 64'(exp_oeb), 64'(o_io_oeb));
endtask

task automatic expect_idle(input string test_name);
    #1;
    check_value({test_name, " io_out"}, 64'(PAD_IDLE), 64'(o_io_out));
    check_value({test_name, " io_oeb"}, 64'(PAD_IDLE), 64'(o_io_oeb));
endtask

task automatic compare_resets(input string test_name, input mux_sel_t sel,
                              input logic [2:0] ena);
    #1;
    check_value({test_name, " design_rst"}, 64'(model_rst(sel, ena)), 64'(o_design_rst));
    check_value({test_name, " design_ena"}, 64'(model_ena(sel)), 64'(o_design_ena));
endtask

// Select a mode, then several random draws of its inputs
task automatic run_pad_map(input string test_name, input mux_sel_t sel);
    @(negedge mux_conf_clk);
    set_controls(sel, 3'b000);
    wait_sync();
    for (int i = 0; i < 6; i++) begin
        randomize_design_outputs();
        randomize_pad_inputs();
        compare_pads(test_name, sel);
        @(negedge mux_conf_clk);
    end
endtask

task automatic test_reset_defaults();
    @(negedge mux_conf_clk);
    randomize_design_outputs();  // Must not reach the pads
    i_design_reset = 3'b101;
    expect_idle("test_reset_defaults");
    check_value("test_reset_defaults design_ena", 64'(0), 64'(o_design_ena));
    check_value("test_reset_defaults design_rst", 64'(3'b101), 64'(o_design_rst));
    @(negedge mux_conf_clk);
    i_design_reset = 3'b010;
    #1;
    check_value("test_reset_defaults design_rst", 64'(3'b010), 64'(o_design_rst));
endtask

task automatic test_sync_latency();
    @(negedge mux_conf_clk);
    set_controls(SEL_PATTERN, 3'b000);
    @(negedge mux_conf_clk);
    expect_idle("test_sync_latency one edge");
    @(negedge mux_conf_clk);
    compare_pads("test_sync_latency pattern", SEL_PATTERN);
    check_value("test_sync_latency pattern bits", 64'(16'h55AA), 64'(o_io_out[31:16]));
    @(negedge mux_conf_clk);
    set_controls(SEL_PATTERN_INV, 3'b000);
    @(negedge mux_conf_clk);
    compare_pads("test_sync_latency one edge", SEL_PATTERN);  // Old mode holds
    @(negedge mux_conf_clk);
    compare_pads("test_sync_latency inverted", SEL_PATTERN_INV);
endtask

task automatic test_design_maps();
    run_pad_map("test_design_maps raybox", SEL_RAYBOX);
    run_pad_map("test_design_maps hyperram", SEL_HYPERRAM);
    run_pad_map("test_design_maps vga_spi_rom", SEL_VGA_SPI_ROM);
endtask

task automatic test_loopback_and_default();
    run_pad_map("test_loopback_and_default loopback", SEL_LOOPBACK);
    for (int i = 0; i < 3; i++) begin
        @(negedge mux_conf_clk);
        set_controls(mux_sel_t'(IDLE_SELS[4*i +: 4]), 3'b000);
        wait_sync();
        randomize_design_outputs();
        randomize_pad_inputs();
        expect_idle("test_loopback_and_default idle");
    end
endtask

// Every enable combination against every select code
task automatic test_reset_sources();
    for (int en = 0; en < 8; en++) begin
        for (int s = 0; s < 16; s++) begin
            @(negedge mux_conf_clk);
            set_controls(mux_sel_t'(s), 3'(en));
            wait_sync();
            i_sys_rst      = 1'($urandom);
            i_design_reset = slot_vec_t'($urandom);
            randomize_pad_inputs();
            compare_resets("test_reset_sources", mux_sel_t'(s), 3'(en));
        end
    end
endtask

/* tests/tb_pad_mux_top.sv */
/*
 * Directed tests of pad_mux_top; random design outputs come from a fixed seed.
 * Inputs change on the falling clock edge, outputs are sampled 1 ns later.
 */
`timescale 1ns/1ps

module tb_pad_mux_top;
    import pad_mux_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;  // Tests take about 440 cycles

    // Named as the DUT ports so the instance connects by name
    logic          mux_conf_clk;
    logic          i_rst_n;
    mux_sel_t      i_mux_sel;
    logic          i_mux_sys_reset_enb;
    logic          i_mux_io5_reset_enb;
    logic          i_mux_auto_reset_enb;
    logic          i_sys_rst;
    pad_vec_t      i_io_in;
    la_vec_t       i_la_in;
    slot_vec_t     i_design_reset;
    logic          i_raybox_hsync;
    logic          i_raybox_vsync;
    logic          i_raybox_tex_csb;
    logic          i_raybox_tex_sclk;
    logic          i_raybox_tex_out0;
    logic          i_raybox_tex_oeb0;
    rgb_t          i_raybox_rgb;
    gpout_t        i_raybox_gpout;
    hyperram_vec_t i_hyperram_io_out;
    hyperram_vec_t i_hyperram_io_oeb;
    tt_byte_t      i_vga_uo_out;
    tt_byte_t      i_vga_uio_out;
    tt_byte_t      i_vga_uio_oe;
    pad_vec_t      o_io_out;
    pad_vec_t      o_io_oeb;
    slot_vec_t     o_design_rst;
    slot_vec_t     o_design_ena;

    int            cycle_count = 0;  // Rising edges since time 0

    pad_mux_top i_pad_mux_top (.*);

    initial begin
        mux_conf_clk = 1'b0;
        forever #2 mux_conf_clk = ~mux_conf_clk;  // 4 ns period
    end

    // Stall guard
    always @(posedge mux_conf_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "Run stopped by timeout");
        end
    end

    `include "tb_pad_mux_tasks.svh"

    initial begin
        void'($urandom(32'hc728_7f55));  // Seed once, before any draw
        i_rst_n   = 1'b0;
        i_mux_sel = 4'd15;                // Same code the synchroniser resets to
        {i_mux_sys_reset_enb, i_mux_io5_reset_enb, i_mux_auto_reset_enb} = 3'b111;
        {i_sys_rst, i_io_in, i_la_in, i_design_reset} = '0;
        {i_raybox_hsync, i_raybox_vsync, i_raybox_tex_csb, i_raybox_tex_sclk,
         i_raybox_tex_out0, i_raybox_tex_oeb0, i_raybox_rgb, i_raybox_gpout} = '0;
        {i_hyperram_io_out, i_hyperram_io_oeb} = '0;
        {i_vga_uo_out, i_vga_uio_out, i_vga_uio_oe} = '0;

        // Three rising edges in reset
        repeat (3) @(negedge mux_conf_clk);
        i_rst_n = 1'b1;

        test_reset_defaults();
        test_sync_latency();
        test_design_maps();
        test_loopback_and_default();
        test_reset_sources();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+tests
hdl/pad_mux_pkg.sv
hdl/mux_ctrl_sync.sv
hdl/design_reset_gen.sv
hdl/pad_mux_select.sv
hdl/pad_mux_top.sv
tests/tb_pad_mux_top.sv

/* Bender.yml */
package:
  name: pad_mux

sources:
  - files:
      - hdl/pad_mux_pkg.sv
      - hdl/mux_ctrl_sync.sv
      - hdl/design_reset_gen.sv
      - hdl/pad_mux_select.sv
      - hdl/pad_mux_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_pad_mux_top.sv
